// File: rtl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and register file geometry
`define RV_XLEN     32
`define RV_NUM_REGS 32
`define RV_REG_AW   5

// program counter behavior
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP  32'd4

`endif

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the kept instruction groups
  typedef enum logic [6:0]
  {
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_BRANCH  = 7'b1100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  // funct3 for the ALU groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for the branch group
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 markers, alt picks sub and sra
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// File: rtl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  typedef enum logic [3:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0]
  {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // only the ALU result can reach the register file
  typedef enum logic
  {
    WB_ALU,
    WB_NONE
  } wb_src_e;

endpackage

// File: rtl/insn_decoder.sv
`include "rv_cfg.svh"

module insn_decoder
(
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic [`RV_REG_AW-1:0] o_rs1,
  output logic [`RV_REG_AW-1:0] o_rs2,
  output logic [`RV_REG_AW-1:0] o_rd,
  output logic [`RV_XLEN-1:0]   o_imm,
  output rv_ctrl_pkg::alu_op_e  o_alu_op,
  output logic                  o_use_imm,
  output logic                  o_use_pc,
  output rv_ctrl_pkg::br_cond_e o_br_cond,
  output rv_ctrl_pkg::wb_src_e  o_wb_src,
  output logic                  o_halt_req
);

  rv_isa_pkg::opcode_e  opcode;
  logic [2:0]           funct3;
  logic                 f7_base;
  logic                 f7_alt;
  logic                 shift_ok;
  logic [`RV_XLEN-1:0]  imm_i;
  logic [`RV_XLEN-1:0]  imm_b;
  logic [`RV_XLEN-1:0]  imm_u;

  assign opcode  = rv_isa_pkg::opcode_e'(i_insn[6:0]);
  assign o_rd    = i_insn[11:7];
  assign funct3  = i_insn[14:12];
  assign o_rs1   = i_insn[19:15];
  assign o_rs2   = i_insn[24:20];
  assign f7_base = i_insn[31:25] == rv_isa_pkg::FUNCT7_BASE;
  assign f7_alt  = i_insn[31:25] == rv_isa_pkg::FUNCT7_ALT;

  // sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7],
                  i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  // funct7 legality for the shift and add/sub slots
  always_comb
  begin
    case (funct3)
      rv_isa_pkg::F3_SLL:     shift_ok = f7_base;
      rv_isa_pkg::F3_SRL_SRA: shift_ok = f7_base || f7_alt;
      default:                shift_ok = 1'b1;
    endcase
  end

  always_comb
  begin
    o_imm      = imm_i;
    o_alu_op   = rv_ctrl_pkg::ALU_ADD;
    o_use_imm  = 1'b0;
    o_use_pc   = 1'b0;
    o_br_cond  = rv_ctrl_pkg::BR_NONE;
    o_wb_src   = rv_ctrl_pkg::WB_NONE;
    o_halt_req = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI:
      begin
        o_imm     = imm_u;
        o_alu_op  = rv_ctrl_pkg::ALU_PASS_B;
        o_use_imm = 1'b1;
        o_wb_src  = rv_ctrl_pkg::WB_ALU;
      end
      rv_isa_pkg::OP_AUIPC:
      begin
        o_imm     = imm_u;
        o_use_imm = 1'b1;
        o_use_pc  = 1'b1;
        o_wb_src  = rv_ctrl_pkg::WB_ALU;
      end
      rv_isa_pkg::OP_REG_IMM, rv_isa_pkg::OP_REG_REG:
      begin
        o_use_imm = opcode == rv_isa_pkg::OP_REG_IMM;
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB:
            // only reg-reg has sub, addi keeps funct7 as immediate bits
            if (!o_use_imm && f7_alt)
              o_alu_op = rv_ctrl_pkg::ALU_SUB;
          rv_isa_pkg::F3_SLL:     o_alu_op = rv_ctrl_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT:     o_alu_op = rv_ctrl_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU:    o_alu_op = rv_ctrl_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:     o_alu_op = rv_ctrl_pkg::ALU_XOR;
          rv_isa_pkg::F3_SRL_SRA: o_alu_op = f7_alt ? rv_ctrl_pkg::ALU_SRA
                                                    : rv_ctrl_pkg::ALU_SRL;
          rv_isa_pkg::F3_OR:      o_alu_op = rv_ctrl_pkg::ALU_OR;
          default:                o_alu_op = rv_ctrl_pkg::ALU_AND;
        endcase
        // reg-reg needs funct7 base or alt in the add/sub and shift slots
        if (o_use_imm ? shift_ok
            : (f7_base || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                      funct3 == rv_isa_pkg::F3_SRL_SRA))))
          o_wb_src = rv_ctrl_pkg::WB_ALU;
      end
      rv_isa_pkg::OP_BRANCH:
      begin
        o_imm = imm_b;
        case (funct3)
          rv_isa_pkg::F3_BEQ:  o_br_cond = rv_ctrl_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE:  o_br_cond = rv_ctrl_pkg::BR_NE;
          rv_isa_pkg::F3_BLT:  o_br_cond = rv_ctrl_pkg::BR_LT;
          rv_isa_pkg::F3_BGE:  o_br_cond = rv_ctrl_pkg::BR_GE;
          rv_isa_pkg::F3_BLTU: o_br_cond = rv_ctrl_pkg::BR_LTU;
          rv_isa_pkg::F3_BGEU: o_br_cond = rv_ctrl_pkg::BR_GEU;
          default:             o_br_cond = rv_ctrl_pkg::BR_NONE;
        endcase
      end
      // ecall only, other system encodings fall through as no-ops
      rv_isa_pkg::OP_SYSTEM: o_halt_req = i_insn[31:7] == '0;
      default:
      begin
      end
    endcase
  end

endmodule

// File: rtl/reg_file.sv
`include "rv_cfg.svh"

module reg_file
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_we,
  input  logic [`RV_REG_AW-1:0] i_rd,
  input  logic [`RV_XLEN-1:0]   i_wdata,
  input  logic [`RV_REG_AW-1:0] i_rs1,
  input  logic [`RV_REG_AW-1:0] i_rs2,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  for (genvar r = 1; r < `RV_NUM_REGS; r++)
  begin : g_reg
    localparam logic [`RV_REG_AW-1:0] IDX = r;

    always_ff @(posedge clk)
    begin
      if (rst)
        regs[r] <= '0;
      else if (i_we && i_rd == IDX)
        regs[r] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rtl/int_alu.sv
`include "rv_cfg.svh"

module int_alu
(
  input  rv_ctrl_pkg::alu_op_e i_alu_op,
  input  logic [`RV_XLEN-1:0]  i_a,
  input  logic [`RV_XLEN-1:0]  i_b,
  output logic [`RV_XLEN-1:0]  o_result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  // shift amount from the low bits of b only
  assign shamt = i_b[SHAMT_W-1:0];
  assign lt_s  = $signed(i_a) < $signed(i_b);
  assign lt_u  = i_a < i_b;

  always_comb
  begin
    case (i_alu_op)
      rv_ctrl_pkg::ALU_ADD:    o_result = i_a + i_b;
      rv_ctrl_pkg::ALU_SUB:    o_result = i_a - i_b;
      rv_ctrl_pkg::ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_ctrl_pkg::ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_ctrl_pkg::ALU_XOR:    o_result = i_a ^ i_b;
      rv_ctrl_pkg::ALU_OR:     o_result = i_a | i_b;
      rv_ctrl_pkg::ALU_AND:    o_result = i_a & i_b;
      rv_ctrl_pkg::ALU_SLL:    o_result = i_a << shamt;
      rv_ctrl_pkg::ALU_SRL:    o_result = i_a >> shamt;
      // sign fill
      rv_ctrl_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
      rv_ctrl_pkg::ALU_PASS_B: o_result = i_b;
      default:                 o_result = '0;
    endcase
  end

endmodule

// File: rtl/branch_unit.sv
`include "rv_cfg.svh"

module branch_unit
(
  input  rv_ctrl_pkg::br_cond_e i_br_cond,
  input  logic [`RV_XLEN-1:0]   i_rs1_data,
  input  logic [`RV_XLEN-1:0]   i_rs2_data,
  input  logic [`RV_XLEN-1:0]   i_pc,
  input  logic [`RV_XLEN-1:0]   i_imm,
  output logic                  o_taken,
  output logic [`RV_XLEN-1:0]   o_target
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = i_rs1_data == i_rs2_data;
  assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u = i_rs1_data < i_rs2_data;

  always_comb
  begin
    case (i_br_cond)
      rv_ctrl_pkg::BR_EQ:  o_taken = eq;
      rv_ctrl_pkg::BR_NE:  o_taken = !eq;
      rv_ctrl_pkg::BR_LT:  o_taken = lt_s;
      rv_ctrl_pkg::BR_GE:  o_taken = !lt_s;
      rv_ctrl_pkg::BR_LTU: o_taken = lt_u;
      rv_ctrl_pkg::BR_GEU: o_taken = !lt_u;
      // not a branch
      default:             o_taken = 1'b0;
    endcase
  end

  // pc relative, immediate already carries bit 0 as zero
  assign o_target = i_pc + i_imm;

endmodule

// File: rtl/retire_unit.sv
`include "rv_cfg.svh"

module retire_unit
(
  input  logic                  clk,
  input  logic                  rst,
  input  rv_ctrl_pkg::wb_src_e  i_wb_src,
  input  logic [`RV_REG_AW-1:0] i_rd,
  input  logic [`RV_XLEN-1:0]   i_alu_result,
  input  logic                  i_taken,
  input  logic [`RV_XLEN-1:0]   i_target,
  input  logic                  i_halt_req,
  output logic [`RV_XLEN-1:0]   o_pc,
  output logic                  o_rf_we,
  output logic [`RV_XLEN-1:0]   o_rf_wdata,
  output logic                  o_halt
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;
  logic                halt_q;

  // halted core holds its pc
  always_comb
  begin
    if (halt_q)
      pc_next = pc_q;
    else if (i_taken)
      pc_next = i_target;
    else
      pc_next = pc_q + `RV_PC_STEP;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q   <= `RV_RESET_PC;
      halt_q <= 1'b0;
    end
    else
    begin
      pc_q <= pc_next;
      // sticky until reset
      if (i_halt_req)
        halt_q <= 1'b1;
    end
  end

  // x0 writes are dropped here and nowhere else
  assign o_rf_we    = (i_wb_src == rv_ctrl_pkg::WB_ALU) && (i_rd != '0) && !halt_q;
  assign o_rf_wdata = i_alu_result;
  assign o_pc       = pc_q;
  assign o_halt     = halt_q;

endmodule

// File: rtl/rv_core.sv
`include "rv_cfg.svh"

module rv_core
(
  input  logic                  clk,
  input  logic                  rst,
  output logic [`RV_XLEN-1:0]   o_pc,
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic                  o_retire_valid,
  output logic [`RV_REG_AW-1:0] o_retire_rd,
  output logic [`RV_XLEN-1:0]   o_retire_data,
  output logic                  o_halt
);

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm;
  rv_ctrl_pkg::alu_op_e  alu_op;
  logic                  use_imm;
  logic                  use_pc;
  rv_ctrl_pkg::br_cond_e br_cond;
  rv_ctrl_pkg::wb_src_e  wb_src;
  logic                  halt_req;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   alu_a;
  logic [`RV_XLEN-1:0]   alu_b;
  logic [`RV_XLEN-1:0]   alu_result;
  logic                  taken;
  logic [`RV_XLEN-1:0]   target;
  logic                  rf_we;
  logic [`RV_XLEN-1:0]   rf_wdata;

  insn_decoder u_decoder
  (
    .i_insn     (i_insn),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_use_imm  (use_imm),
    .o_use_pc   (use_pc),
    .o_br_cond  (br_cond),
    .o_wb_src   (wb_src),
    .o_halt_req (halt_req)
  );

  reg_file u_reg_file
  (
    .clk        (clk),
    .rst        (rst),
    .i_we       (rf_we),
    .i_rd       (rd),
    .i_wdata    (rf_wdata),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // operand selects, pc for auipc and immediate for the I and U forms
  assign alu_a = use_pc ? o_pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  int_alu u_alu
  (
    .i_alu_op (alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  branch_unit u_branch
  (
    .i_br_cond  (br_cond),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_pc       (o_pc),
    .i_imm      (imm),
    .o_taken    (taken),
    .o_target   (target)
  );

  retire_unit u_retire
  (
    .clk          (clk),
    .rst          (rst),
    .i_wb_src     (wb_src),
    .i_rd         (rd),
    .i_alu_result (alu_result),
    .i_taken      (taken),
    .i_target     (target),
    .i_halt_req   (halt_req),
    .o_pc         (o_pc),
    .o_rf_we      (rf_we),
    .o_rf_wdata   (rf_wdata),
    .o_halt       (o_halt)
  );

  // trace mirrors the register file write port
  assign o_retire_valid = rf_we;
  assign o_retire_rd    = rd;
  assign o_retire_data  = rf_wdata;

endmodule

// File: tb/rv_core_tb.sv
module rv_core_tb;

  localparam int          DATA_WORDS = 256;
  localparam int          HALT_HOLD  = 5;
  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  // addi x31, x0, -1 served past the end of each program
  localparam logic [31:0] FILL_INSN  = 32'hFFF0_0F93;

  logic        clk;
  logic        rst = 1'b1;
  logic [31:0] pc;
  logic [31:0] insn;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halt;

  logic [31:0] data [0:DATA_WORDS-1];
  logic [7:0]  prog_off;
  logic [31:0] prog_len;
  logic [7:0]  exp_idx;
  logic [7:0]  exp_end;
  logic [7:0]  imem_idx;
  logic        in_prog;
  int          cycles = 0;
  int          cycle_limit;
  int          errors;
  int          test_errors;
  int          tests_failed;

  rv_core dut
  (
    .clk            (clk),
    .rst            (rst),
    .o_pc           (pc),
    .i_insn         (insn),
    .o_retire_valid (retire_valid),
    .o_retire_rd    (retire_rd),
    .o_retire_data  (retire_data),
    .o_halt         (halt)
  );

  // instruction memory, current test program seen at pc 0
  assign in_prog  = {2'b00, pc[31:2]} < prog_len;
  assign imem_idx = prog_off + pc[9:2];
  assign insn     = in_prog ? data[imem_idx] : FILL_INSN;

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  // match one register write against the next trace record
  task automatic compare_retire();
    if (exp_idx >= exp_end)
    begin
      $display("unexpected retire of x%0d with value %h at time %0t",
               retire_rd, retire_data, $time);
      errors++;
      test_errors++;
    end
    else
    begin
      check_value("retire rd", {27'b0, retire_rd}, data[exp_idx]);
      check_value("retire data", retire_data, data[exp_idx + 8'd1]);
      exp_idx = exp_idx + 8'd2;
    end
  endtask

  task automatic run_test(input int t);
    logic [7:0]  base;
    logic [31:0] halt_pc;
    base        = 8'(1 + 5 * t);
    test_errors = 0;
    prog_off    = data[base][7:0];
    prog_len    = data[base + 8'd1];
    exp_idx     = data[base + 8'd2][7:0];
    exp_end     = exp_idx + 8'(2 * data[base + 8'd3]);
    halt_pc     = data[base + 8'd4];
    apply_reset();
    @(negedge clk);
    // every program opens with a nop, so nothing retires here
    check_value("pc after reset", pc, RESET_PC);
    check_value("halt after reset", {31'b0, halt}, 32'd0);
    check_value("retire after reset", {31'b0, retire_valid}, 32'd0);
    while (halt !== 1'b1)
    begin
      if (retire_valid)
        compare_retire();
      @(negedge clk);
    end
    repeat (HALT_HOLD)
    begin
      check_value("pc while halted", pc, halt_pc);
      check_value("halt flag", {31'b0, halt}, 32'd1);
      check_value("retire while halted", {31'b0, retire_valid}, 32'd0);
      @(negedge clk);
    end
    check_value("trace position at halt", {24'b0, exp_idx}, {24'b0, exp_end});
    if (test_errors == 0)
      $display("test %0d passed", t);
    else
    begin
      $display("test %0d failed with %0d errors", t, test_errors);
      tests_failed++;
    end
  endtask

  initial
  begin : main
    int num_tests;
    prog_off     = 8'd0;
    prog_len     = 32'd0;
    exp_idx      = 8'd0;
    exp_end      = 8'd0;
    errors       = 0;
    tests_failed = 0;
    $readmemh("tb/rv_core_testdata.txt", data);
    num_tests   = int'(data[0]);
    // twice the program length plus 20 for each test
    cycle_limit = 0;
    for (int t = 0; t < num_tests; t++)
      cycle_limit = cycle_limit + 2 * int'(data[8'(2 + 5 * t)]) + 20;
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: tb/rv_core_testdata.txt
// word 0 holds the test count, then one descriptor line per test
// descriptor columns: program offset, program words, trace offset, trace records, halt pc
@000
00000004
@001
00000020 0000000C 00000030 0000000A 00000030
00000050 00000010 00000060 0000000D 00000040
00000080 00000006 00000088 00000004 00000018
00000090 0000001C 000000B0 00000008 00000070
// trace record columns: rd, value
// test 0: addi slti sltiu xori ori andi slli srli srai, ecall
@020
00000013 06400093 FFB00113 00112193 00113213 0FF0C293
7000E313 0F017393 00409413 01C15493 40115513 00000073
@030
00000001 00000064  00000002 FFFFFFFB  00000003 00000001  00000004 00000000
00000005 0000009B  00000006 00000764  00000007 000000F0  00000008 00000640
00000009 0000000F  0000000A FFFFFFFD
// test 1: add sub slt sltu xor or and sll srl sra, write to x0, read of x0
@050
00000013 FF800093 00300113 002081B3 40110233 0020A2B3 0020B333 0020C3B3
0020E433 0020F4B3 00211533 0020D5B3 4020D633 00208033 000006B3 00000073
@060
00000001 FFFFFFF8  00000002 00000003  00000003 FFFFFFFB  00000004 0000000B
00000005 00000001  00000006 00000000  00000007 FFFFFFFB  00000008 FFFFFFFB
00000009 00000000  0000000A 00000018  0000000B 1FFFFFFF  0000000C FFFFFFFF
0000000D 00000000
// test 2: lui and auipc
@080
00000013 123450B7 00001117 FFFFF1B7 80000217 00000073
@088
00000001 12345000  00000002 00001008  00000003 FFFFF000  00000004 80000010
// test 3: each branch not taken then taken, FFF00F93 is the poisoned word
@090
00000013 FFF00093 00100113
00208463 00118193 00108463 FFF00F93
00109463 00118193 00209463 FFF00F93
00114463 00118193 0020C463 FFF00F93
0020D463 00118193 00115463 FFF00F93
0020E463 00118193 00116463 FFF00F93
00117463 00118193 0020F463 FFF00F93
00000073
@0B0
00000001 FFFFFFFF  00000002 00000001  00000003 00000001  00000003 00000002
00000003 00000003  00000003 00000004  00000003 00000005  00000003 00000006

// File: rv_core.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/insn_decoder.sv
rtl/reg_file.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/retire_unit.sv
rtl/rv_core.sv
tb/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
fi
echo "simulation reported failure, see $LOG"
exit 1
